// File: src/z88_bus_config.svh
`ifndef Z88_BUS_CONFIG_SVH
`define Z88_BUS_CONFIG_SVH

// First of the four segment bank register ports (0xD0 to 0xD3)
`define Z88_BANK_PORT_BASE 8'hD0

// CPU data bus width
`define Z88_DATA_W 8

// CPU logical address width
`define Z88_CPU_AW 16

// Banked memory address width, 256 banks of 16 KB
`define Z88_MEM_AW 22

`endif

// File: src/z88_bus_pkg.sv
`default_nettype none

package z88_bus_pkg;

  // Kind of bus cycle the CPU is running right now
  typedef enum logic [2:0] {
    CYC_IDLE   = 3'd0,
    CYC_MEM_RD = 3'd1,
    CYC_MEM_WR = 3'd2,
    CYC_IO_RD  = 3'd3,
    CYC_IO_WR  = 3'd4
  } bus_cycle_e;

  // Memory target behind the current segment
  // Bank bits 7:6 pick the slot, bit 5 picks RAM inside slot 0
  typedef enum logic [2:0] {
    SLOT_ROM   = 3'd0,
    SLOT_RAM   = 3'd1,
    SLOT_CARD1 = 3'd2,
    SLOT_CARD2 = 3'd3,
    SLOT_CARD3 = 3'd4
  } slot_e;

endpackage

`default_nettype wire

// File: src/blink_cycle_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "z88_bus_config.svh"

module blink_cycle_decode (
  // Inputs
  input  wire logic                   clk,
  input  wire logic                   arst_n,
  input  wire logic                   mreq_n,
  input  wire logic                   iorq_n,
  input  wire logic                   rd_n,
  input  wire logic                   wr_n,
  input  wire logic [`Z88_CPU_AW-1:0] ca,

  // Outputs
  output z88_bus_pkg::bus_cycle_e     cycle,
  output logic                        io_wr_pulse
);

  localparam logic [7:0] BANK_PORT = `Z88_BANK_PORT_BASE;

  logic io_wr_prev;
  logic bank_port_hit;
  logic io_wr_start;

  // Strobe classification, memory request has priority
  always_comb begin
    cycle = z88_bus_pkg::CYC_IDLE;
    if (!mreq_n) begin
      if (!rd_n) begin
        cycle = z88_bus_pkg::CYC_MEM_RD;
      end else if (!wr_n) begin
        cycle = z88_bus_pkg::CYC_MEM_WR;
      end
    end else if (!iorq_n) begin
      if (!rd_n) begin
        cycle = z88_bus_pkg::CYC_IO_RD;
      end else if (!wr_n) begin
        cycle = z88_bus_pkg::CYC_IO_WR;
      end
    end
  end

  // Ports 0xD0..0xD3 share the upper six address bits
  assign bank_port_hit = (ca[7:2] == BANK_PORT[7:2]);

  // First sampled edge of an I/O write to a bank port
  assign io_wr_start = (cycle == z88_bus_pkg::CYC_IO_WR) && !io_wr_prev && bank_port_hit;

  // One pulse per write, however long the CPU holds the strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      io_wr_prev  <= 1'b0;
      io_wr_pulse <= 1'b0;
    end else begin
      io_wr_prev  <= (cycle == z88_bus_pkg::CYC_IO_WR);
      io_wr_pulse <= io_wr_start;
    end
  end

endmodule

`default_nettype wire

// File: src/blink_segment_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "z88_bus_config.svh"

module blink_segment_regs (
  // Inputs
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    io_wr_pulse,
  input  wire z88_bus_pkg::bus_cycle_e cycle,
  input  wire logic [`Z88_CPU_AW-1:0]  ca,
  input  wire logic [`Z88_DATA_W-1:0]  cdo,

  // Outputs
  output logic [`Z88_MEM_AW-1:0]       ma,
  output z88_bus_pkg::slot_e           slot,
  output logic                         rom_ce_n,
  output logic                         ram_ce_n,
  output logic                         se1_n,
  output logic                         se2_n,
  output logic                         se3_n,
  output logic [`Z88_DATA_W-1:0]       bank_rd_data
);

  // Bank number width, the part of ma above the 16 KB offset
  localparam int BANK_W = `Z88_MEM_AW - 14;

  logic [BANK_W-1:0] bank [4];
  logic [BANK_W-1:0] cur_bank;
  logic              mem_cycle;

  // SR0..SR3, written through ports 0xD0..0xD3
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 4; i++) begin
        bank[i] <= '0;
      end
    end else if (io_wr_pulse) begin
      bank[ca[1:0]] <= cdo;
    end
  end

  // Segment chosen by the top two CPU address bits
  assign cur_bank = bank[ca[15:14]];
  assign ma       = {cur_bank, ca[13:0]};

  assign bank_rd_data = bank[ca[1:0]];

  // Slot decode from bank bits 7:6, RAM select on bit 5
  always_comb begin
    case (cur_bank[7:6])
      2'd0:    slot = cur_bank[5] ? z88_bus_pkg::SLOT_RAM : z88_bus_pkg::SLOT_ROM;
      2'd1:    slot = z88_bus_pkg::SLOT_CARD1;
      2'd2:    slot = z88_bus_pkg::SLOT_CARD2;
      default: slot = z88_bus_pkg::SLOT_CARD3;
    endcase
  end

  assign mem_cycle = (cycle == z88_bus_pkg::CYC_MEM_RD) ||
                     (cycle == z88_bus_pkg::CYC_MEM_WR);

  // Only one select goes low, and only in a memory cycle
  assign rom_ce_n = !(mem_cycle && (slot == z88_bus_pkg::SLOT_ROM));
  assign ram_ce_n = !(mem_cycle && (slot == z88_bus_pkg::SLOT_RAM));
  assign se1_n    = !(mem_cycle && (slot == z88_bus_pkg::SLOT_CARD1));
  assign se2_n    = !(mem_cycle && (slot == z88_bus_pkg::SLOT_CARD2));
  assign se3_n    = !(mem_cycle && (slot == z88_bus_pkg::SLOT_CARD3));

endmodule

`default_nettype wire

// File: src/blink_bus_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "z88_bus_config.svh"

module blink_bus_mux (
  // Inputs
  input  wire z88_bus_pkg::bus_cycle_e cycle,
  input  wire z88_bus_pkg::slot_e      slot,
  input  wire logic [`Z88_CPU_AW-1:0]  ca,
  input  wire logic [`Z88_DATA_W-1:0]  rom_do,
  input  wire logic [`Z88_DATA_W-1:0]  ram_do,
  input  wire logic [`Z88_DATA_W-1:0]  bank_rd_data,
  input  wire logic [`Z88_DATA_W-1:0]  cdo,

  // Outputs
  output logic [`Z88_DATA_W-1:0]       cdi,
  output logic [`Z88_DATA_W-1:0]       mem_di,
  output logic                         roe_n,
  output logic                         wrb_n
);

  localparam logic [7:0] BANK_PORT = `Z88_BANK_PORT_BASE;

  // Floating bus reads as all ones
  localparam logic [`Z88_DATA_W-1:0] BUS_IDLE = '1;

  logic bank_port_hit;
  logic mem_rd;
  logic mem_wr;

  assign bank_port_hit = (ca[7:2] == BANK_PORT[7:2]);

  assign mem_rd = (cycle == z88_bus_pkg::CYC_MEM_RD);
  assign mem_wr = (cycle == z88_bus_pkg::CYC_MEM_WR);

  // Read data steering back to the CPU
  always_comb begin
    cdi = BUS_IDLE;
    case (cycle)
      z88_bus_pkg::CYC_MEM_RD: begin
        case (slot)
          z88_bus_pkg::SLOT_ROM: cdi = rom_do;
          z88_bus_pkg::SLOT_RAM: cdi = ram_do;
          // Empty card slots
          default:               cdi = BUS_IDLE;
        endcase
      end
      z88_bus_pkg::CYC_IO_RD: begin
        if (bank_port_hit) begin
          cdi = bank_rd_data;
        end
      end
      default: begin
        cdi = BUS_IDLE;
      end
    endcase
  end

  // Shared output enable for every memory
  assign roe_n = !mem_rd;

  // ROM is never written
  assign wrb_n = !(mem_wr && (slot != z88_bus_pkg::SLOT_ROM));

  assign mem_di = cdo;

endmodule

`default_nettype wire

// File: src/z88_bus.sv
`timescale 1ns/1ns
`default_nettype none

`include "z88_bus_config.svh"

module z88_bus (
  // Clock, reset
  input  wire logic                    clk,
  input  wire logic                    arst_n,

  // CPU bus
  input  wire logic [`Z88_CPU_AW-1:0]  ca,
  input  wire logic                    mreq_n,
  input  wire logic                    iorq_n,
  input  wire logic                    rd_n,
  input  wire logic                    wr_n,
  input  wire logic [`Z88_DATA_W-1:0]  cdo,
  output logic [`Z88_DATA_W-1:0]       cdi,

  // Memory and card slots
  output logic [`Z88_MEM_AW-1:0]       ma,
  output logic                         rom_ce_n,
  output logic                         ram_ce_n,
  output logic                         se1_n,
  output logic                         se2_n,
  output logic                         se3_n,
  output logic                         roe_n,
  output logic                         wrb_n,
  output logic [`Z88_DATA_W-1:0]       mem_di,
  input  wire logic [`Z88_DATA_W-1:0]  rom_do,
  input  wire logic [`Z88_DATA_W-1:0]  ram_do
);

  z88_bus_pkg::bus_cycle_e  cycle;
  z88_bus_pkg::slot_e       slot;
  logic                     io_wr_pulse;
  logic [`Z88_DATA_W-1:0]   bank_rd_data;

  blink_cycle_decode cycle_decode_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .mreq_n      (mreq_n),
    .iorq_n      (iorq_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .ca          (ca),
    .cycle       (cycle),
    .io_wr_pulse (io_wr_pulse)
  );

  // Bank registers, address translation and chip selects
  blink_segment_regs segment_regs_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .io_wr_pulse  (io_wr_pulse),
    .cycle        (cycle),
    .ca           (ca),
    .cdo          (cdo),
    .ma           (ma),
    .slot         (slot),
    .rom_ce_n     (rom_ce_n),
    .ram_ce_n     (ram_ce_n),
    .se1_n        (se1_n),
    .se2_n        (se2_n),
    .se3_n        (se3_n),
    .bank_rd_data (bank_rd_data)
  );

  blink_bus_mux bus_mux_inst (
    .cycle        (cycle),
    .slot         (slot),
    .ca           (ca),
    .rom_do       (rom_do),
    .ram_do       (ram_do),
    .bank_rd_data (bank_rd_data),
    .cdo          (cdo),
    .cdi          (cdi),
    .mem_di       (mem_di),
    .roe_n        (roe_n),
    .wrb_n        (wrb_n)
  );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for five rising edges, released away from the edge
  initial begin
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tb_bus_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bus_checker (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic [15:0] ca,
  input  wire logic        mreq_n,
  input  wire logic        iorq_n,
  input  wire logic        rd_n,
  input  wire logic        wr_n,
  input  wire logic [7:0]  cdo,
  input  wire logic [7:0]  cdi,
  input  wire logic [7:0]  mem_di,
  input  wire logic [21:0] ma,
  // Order is rom, ram, se1, se2, se3
  input  wire logic [4:0]  ce_n,
  input  wire logic        roe_n,
  input  wire logic        wrb_n,
  input  wire logic        test_end,
  input  wire logic [31:0] test_num,
  output int               err_count,
  output int               check_count,
  output logic             timed_out
);

  localparam int MAX_CYCLES = 4000;

  logic [7:0]  bank [4];
  logic [7:0]  ram [1024];
  logic        wr_prev;
  logic        wr_pend;
  logic [36:0] exp_bus;
  logic [36:0] act_bus;
  int          cycles;
  int          errs_before;
  z88_bus_pkg::bus_cycle_e cyc;

  function automatic z88_bus_pkg::bus_cycle_e classify(input logic m_n, io_n, r_n, w_n);
    if (!m_n && !r_n) return z88_bus_pkg::CYC_MEM_RD;
    if (!m_n && !w_n) return z88_bus_pkg::CYC_MEM_WR;
    if (!io_n && !r_n) return z88_bus_pkg::CYC_IO_RD;
    if (!io_n && !w_n) return z88_bus_pkg::CYC_IO_WR;
    return z88_bus_pkg::CYC_IDLE;
  endfunction

  function automatic z88_bus_pkg::slot_e target_of(input logic [7:0] b);
    if (b[7:6] == 2'd1) return z88_bus_pkg::SLOT_CARD1;
    if (b[7:6] == 2'd2) return z88_bus_pkg::SLOT_CARD2;
    if (b[7:6] == 2'd3) return z88_bus_pkg::SLOT_CARD3;
    return b[5] ? z88_bus_pkg::SLOT_RAM : z88_bus_pkg::SLOT_ROM;
  endfunction

  // Expected {ma, selects, roe_n, wrb_n, cdi} from the shadow state
  function automatic logic [36:0] expect_bus(input z88_bus_pkg::bus_cycle_e c,
                                             input logic [15:0] a);
    logic [21:0]        m;
    logic [4:0]         sel;
    logic [7:0]         d;
    z88_bus_pkg::slot_e s;
    m   = {bank[a[15:14]], a[13:0]};
    s   = target_of(bank[a[15:14]]);
    sel = 5'b11111;
    d   = 8'hFF;
    if (c == z88_bus_pkg::CYC_MEM_RD || c == z88_bus_pkg::CYC_MEM_WR) begin
      case (s)
        z88_bus_pkg::SLOT_ROM:   sel = 5'b01111;
        z88_bus_pkg::SLOT_RAM:   sel = 5'b10111;
        z88_bus_pkg::SLOT_CARD1: sel = 5'b11011;
        z88_bus_pkg::SLOT_CARD2: sel = 5'b11101;
        default:                 sel = 5'b11110;
      endcase
    end
    if (c == z88_bus_pkg::CYC_MEM_RD && s == z88_bus_pkg::SLOT_ROM) begin
      d = m[7:0] ^ m[21:14];
    end else if (c == z88_bus_pkg::CYC_MEM_RD && s == z88_bus_pkg::SLOT_RAM) begin
      d = ram[m[9:0]];
    end else if (c == z88_bus_pkg::CYC_IO_RD && a[7:0] >= 8'hD0 && a[7:0] <= 8'hD3) begin
      d = bank[a[1:0]];
    end
    return {m, sel, c != z88_bus_pkg::CYC_MEM_RD,
            !(c == z88_bus_pkg::CYC_MEM_WR && s != z88_bus_pkg::SLOT_ROM), d};
  endfunction

  initial begin
    err_count   = 0;
    check_count = 0;
    errs_before = 0;
    cycles      = 0;
    timed_out   = 1'b0;
    // Same fill as the RAM model
    for (int i = 0; i < 1024; i++) begin
      ram[i] = i[7:0] ^ {6'd0, i[9:8]};
    end
  end

  always @(posedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < 4; i++) begin
        bank[i] = 8'h00;
      end
      wr_prev = 1'b0;
      wr_pend = 1'b0;
    end else begin
      cyc     = classify(mreq_n, iorq_n, rd_n, wr_n);
      exp_bus = expect_bus(cyc, ca);
      act_bus = {ma, ce_n, roe_n, wrb_n, cdi};
      check_count++;
      if (act_bus !== exp_bus) begin
        err_count++;
        $display("Fail at %0t ns: ca=%h expected ma=%h ce_n=%b roe/wrb=%b cdi=%h",
                 $time, ca, exp_bus[36:15], exp_bus[14:10], exp_bus[9:8], exp_bus[7:0]);
        $display("  got ma=%h ce_n=%b roe/wrb=%b cdi=%h",
                 ma, ce_n, {roe_n, wrb_n}, cdi);
      end
      // Memory write data must be the byte the CPU is writing
      if (cyc == z88_bus_pkg::CYC_MEM_WR && mem_di !== cdo) begin
        err_count++;
        $display("Fail at %0t ns: ca=%h expected mem_di=%h got %h",
                 $time, ca, cdo, mem_di);
      end
      if (cyc == z88_bus_pkg::CYC_MEM_WR && !exp_bus[13]) begin
        ram[ca[9:0]] = cdo;
      end
      // Register update lands one edge after the first sampled write edge
      if (wr_pend) begin
        bank[ca[1:0]] = cdo;
      end
      wr_pend = (cyc == z88_bus_pkg::CYC_IO_WR) && !wr_prev &&
                (ca[7:0] >= 8'hD0) && (ca[7:0] <= 8'hD3);
      wr_prev = (cyc == z88_bus_pkg::CYC_IO_WR);
      if (test_end) begin
        $display("Test %0d done: %0d errors", test_num, err_count - errs_before);
        errs_before = err_count;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      timed_out = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_z88_bus.sv
`timescale 1ns/1ns
`default_nettype none

module tb_z88_bus;

  logic        clk;
  logic        arst_n;
  logic [15:0] ca;
  logic        mreq_n;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic [7:0]  cdo;
  logic [7:0]  cdi;
  logic [21:0] ma;
  logic        rom_ce_n;
  logic        ram_ce_n;
  logic        se1_n;
  logic        se2_n;
  logic        se3_n;
  logic        roe_n;
  logic        wrb_n;
  logic [7:0]  mem_di;
  logic [7:0]  rom_do;
  logic [7:0]  ram_do;
  logic [7:0]  ram [1024];
  logic        test_end;
  int          test_num;
  int          err_count;
  int          check_count;
  logic        timed_out;
  integer      seed;
  logic [31:0] rnd;

  tb_clock_gen clock_gen_inst (.clk(clk), .arst_n(arst_n));

  z88_bus z88_bus_inst (.*);

  tb_bus_checker checker_inst (.ce_n({rom_ce_n, ram_ce_n, se1_n, se2_n, se3_n}), .*);

  // ROM content is a function of the full memory address
  assign rom_do = ma[7:0] ^ ma[21:14];

  // Small RAM, aliased on the low address bits
  assign ram_do = ram[ma[9:0]];

  always @(posedge clk) begin
    if (!ram_ce_n && !wrb_n) begin
      ram[ma[9:0]] <= mem_di;
    end
  end

  initial begin
    for (int i = 0; i < 1024; i++) begin
      ram[i] = i[7:0] ^ {6'd0, i[9:8]};
    end
  end

  // One CPU cycle, strobes held for hold cycles and then one idle cycle
  task automatic bus_cycle(input logic [15:0] a, input logic mem, input logic wr,
                           input logic [7:0] d, input int hold);
    ca     = a;
    cdo    = d;
    mreq_n = !mem;
    iorq_n = mem;
    rd_n   = wr;
    wr_n   = !wr;
    repeat (hold) @(negedge clk);
    mreq_n = 1'b1;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    wr_n   = 1'b1;
    @(negedge clk);
  endtask

  // Held I/O write whose data changes after the register has taken it
  task automatic held_io_write(input logic [7:0] port, input logic [7:0] d0,
                               input logic [7:0] d1, input int hold);
    ca     = {8'h00, port};
    cdo    = d0;
    mreq_n = 1'b1;
    iorq_n = 1'b0;
    rd_n   = 1'b1;
    wr_n   = 1'b0;
    repeat (2) @(negedge clk);
    cdo = d1;
    repeat (hold - 2) @(negedge clk);
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    @(negedge clk);
  endtask

  task automatic io_write(input logic [7:0] port, input logic [7:0] d);
    bus_cycle({8'h00, port}, 1'b0, 1'b1, d, 3);
  endtask

  task automatic io_read(input logic [7:0] port);
    bus_cycle({8'h00, port}, 1'b0, 1'b0, 8'h00, 1);
  endtask

  task automatic mem_read(input logic [15:0] a);
    bus_cycle(a, 1'b1, 1'b0, 8'h00, 1);
  endtask

  task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
    bus_cycle(a, 1'b1, 1'b1, d, 1);
  endtask

  task automatic finish_test(input int n);
    test_num = n;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    wait (timed_out === 1'b1);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed     = 39;
    ca       = 16'h0000;
    mreq_n   = 1'b1;
    iorq_n   = 1'b1;
    rd_n     = 1'b1;
    wr_n     = 1'b1;
    cdo      = 8'h00;
    test_end = 1'b0;
    test_num = 0;
    wait (arst_n === 1'b1);
    @(negedge clk);

    // Idle selects, then ROM bank 0 in every segment
    repeat (4) @(negedge clk);
    mem_read(16'h0123);
    mem_read(16'h4567);
    mem_read(16'h89AB);
    mem_read(16'hCDEF);
    finish_test(1);

    io_write(8'hD0, 8'h20);
    io_write(8'hD1, 8'h41);
    io_write(8'hD2, 8'h82);
    io_write(8'hD3, 8'hC3);
    io_write(8'hD4, 8'h5A);
    io_write(8'hCF, 8'hA5);
    io_write(8'h13, 8'h3C);
    for (int p = 0; p < 4; p++) begin
      io_read(8'(208 + p));
    end
    finish_test(2);

    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      io_write(8'(208 + i % 4), rnd[7:0]);
      mem_read({2'(i % 4), rnd[21:8]});
      mem_write({2'(i % 4), rnd[29:16]}, rnd[15:8]);
    end
    finish_test(3);

    // RAM bank in segment 1, ROM bank in segment 2
    io_write(8'hD1, 8'h25);
    mem_write(16'h4155, 8'h5A);
    mem_read(16'h4155);
    io_write(8'hD2, 8'h03);
    mem_write(16'h8010, 8'hA5);
    mem_read(16'h8010);
    finish_test(4);

    io_write(8'hD3, 8'h47);
    mem_read(16'hC001);
    io_write(8'hD3, 8'h9F);
    mem_read(16'hC002);
    io_write(8'hD3, 8'hE0);
    mem_read(16'hC003);
    io_read(8'h00);
    io_read(8'hD4);
    io_read(8'hFF);
    finish_test(5);

    // Long held write, then two writes to one port
    held_io_write(8'hD0, 8'h33, 8'h66, 9);
    io_read(8'hD0);
    mem_read(16'h0042);
    io_write(8'hD1, 8'h11);
    io_write(8'hD1, 8'h2A);
    io_read(8'hD1);
    mem_read(16'h4042);
    finish_test(6);

    repeat (2) @(negedge clk);
    $display("Summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0 && check_count > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/z88_bus_pkg.sv
src/blink_cycle_decode.sv
src/blink_segment_regs.sv
src/blink_bus_mux.sv
src/z88_bus.sv
bench/tb_clock_gen.sv
bench/tb_bus_checker.sv
bench/tb_z88_bus.sv

// File: Bender.yml
package:
  name: z88_bus

export_include_dirs:
  - src

sources:
  - src/z88_bus_pkg.sv
  - src/blink_cycle_decode.sv
  - src/blink_segment_regs.sv
  - src/blink_bus_mux.sv
  - src/z88_bus.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_bus_checker.sv
      - bench/tb_z88_bus.sv
